// File: include/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Data word width
`define CSR_XLEN 32

// Entries in the command FIFO between intake and CSR file
`define CSR_QUEUE_DEPTH 4

// Fixed hart id, read back through mhartid
`define CSR_HART_ID 0

// RV32 (MXL = 1) with the I and U extensions
`define CSR_MISA_VALUE 32'h4010_0100

// Implementation id
`define CSR_MIMPID_VALUE 1

`endif

// File: logic/csr_isa_pkg.sv
`include "csr_config.svh"

package csr_isa_pkg;

   // Implemented CSR addresses
   typedef enum logic [11:0]
   {
      e_csr_mstatus  = 12'h300,
      e_csr_misa     = 12'h301,
      e_csr_mie      = 12'h304,
      e_csr_mtvec    = 12'h305,
      e_csr_mscratch = 12'h340,
      e_csr_mepc     = 12'h341,
      e_csr_mcause   = 12'h342,
      e_csr_mip      = 12'h344,
      e_csr_minstret = 12'hb02,
      e_csr_mimpid   = 12'hf13,
      e_csr_mhartid  = 12'hf14
   } csr_addr_e;

   // CSR forms follow funct3
   typedef enum logic [3:0]
   {
      e_ecall  = 4'd0,
      e_csrrw  = 4'd1,
      e_csrrs  = 4'd2,
      e_csrrc  = 4'd3,
      e_csrrwi = 4'd5,
      e_csrrsi = 4'd6,
      e_csrrci = 4'd7,
      e_mret   = 4'd8
   } csr_op_e;

   typedef enum logic [1:0]
   {
      e_priv_u = 2'd0,
      e_priv_m = 2'd3
   } priv_e;

   localparam logic [3:0] cause_illegal_instr = 4'd2;
   localparam logic [3:0] cause_ecall_u       = 4'd8;
   localparam logic [3:0] cause_ecall_m       = 4'd11;
   localparam logic [3:0] cause_irq_software  = 4'd3;
   localparam logic [3:0] cause_irq_timer     = 4'd7;
   localparam logic [3:0] cause_irq_external  = 4'd11;

   typedef struct packed {
      logic [`CSR_XLEN-1:13] rsvd_hi;
      logic [1:0]            mpp;
      logic [2:0]            rsvd_mid;
      logic                  mpie;
      logic [2:0]            rsvd_lo;
      logic                  mie;
      logic [2:0]            rsvd_wpri;
   } mstatus_s;

   // Same write word, seen raw or as mstatus fields
   typedef union packed {
      logic [`CSR_XLEN-1:0] raw;
      mstatus_s             mstatus;
   } csr_word_u;

endpackage

// File: logic/csr_link_pkg.sv
`include "csr_config.svh"

package csr_link_pkg;

   // One command as it moves from intake through the queue to the CSR file
   typedef struct packed {
      csr_isa_pkg::csr_op_e op;
      logic [11:0]          addr;
      // rs1 value, or the immediate in the low five bits
      logic [`CSR_XLEN-1:0] data;
      logic [`CSR_XLEN-1:0] pc;
   } csr_cmd_s;

endpackage

// File: logic/csr_cmd_if.sv
interface csr_cmd_if;

   import csr_link_pkg::*;

   // Four-phase: cmd is stable while req is high
   logic     req;
   logic     ack;
   csr_cmd_s cmd;

   modport source
   (
      output req,
      output cmd,
      input  ack
   );

   modport sink
   (
      input  req,
      input  cmd,
      output ack
   );

endinterface

// File: logic/csr_cmd_intake.sv
`include "csr_config.svh"

module csr_cmd_intake
  (input                          clk_i
   , input                        rst_i
   , input                        cmd_req_i
   , output logic                 cmd_ack_o
   , input csr_isa_pkg::csr_op_e  cmd_op_i
   , input [11:0]                 cmd_addr_i
   , input [`CSR_XLEN-1:0]        cmd_data_i
   , input [`CSR_XLEN-1:0]        cmd_pc_i
   , csr_cmd_if.source            q_in
   );

   import csr_link_pkg::*;

   typedef enum logic [1:0] {s_idle, s_capture, s_forward, s_release} state_e;

   state_e   state_r;
   csr_cmd_s cmd_r;

   assign q_in.cmd = cmd_r;

   always_ff @(posedge clk_i)
   begin
      if (state_r == s_idle && cmd_req_i)
         cmd_r <= '{op: cmd_op_i, addr: cmd_addr_i, data: cmd_data_i, pc: cmd_pc_i};
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r   <= s_idle;
         cmd_ack_o <= 1'b0;
         q_in.req  <= 1'b0;
      end
      else
      begin
         case (state_r)
            s_idle:
               if (cmd_req_i)
               begin
                  cmd_ack_o <= 1'b1;
                  state_r   <= s_capture;
               end
            s_capture:
            begin
               q_in.req <= 1'b1;
               state_r  <= s_forward;
            end
            s_forward:
               if (q_in.ack)
               begin
                  q_in.req <= 1'b0;
                  state_r  <= s_release;
               end
            // Outside ack drops only after the queue took the command
            s_release:
               if (!q_in.ack && !cmd_req_i)
               begin
                  cmd_ack_o <= 1'b0;
                  state_r   <= s_idle;
               end
            default:
               state_r <= s_idle;
         endcase
      end
   end

endmodule

// File: logic/csr_cmd_queue.sv
`include "csr_config.svh"

module csr_cmd_queue
  (input                clk_i
   , input              rst_i
   , csr_cmd_if.sink    q_in
   , csr_cmd_if.source  q_out
   );

   import csr_link_pkg::*;

   localparam int depth = `CSR_QUEUE_DEPTH;
   localparam int ptr_w = $clog2(depth);
   localparam int cnt_w = $clog2(depth + 1);

   typedef enum logic [1:0] {s_out_idle, s_out_req, s_out_drain} out_state_e;

   csr_cmd_s         mem [depth];
   logic [ptr_w-1:0] wr_ptr_r;
   logic [ptr_w-1:0] rd_ptr_r;
   logic [cnt_w-1:0] count_r;
   out_state_e       out_state_r;
   logic             full;
   logic             push;
   logic             pop;

   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full = (count_r == cnt_w'(depth));
   assign push = q_in.req && !q_in.ack && !full;
   // Head leaves once the consumer has released its ack
   assign pop  = (out_state_r == s_out_drain) && !q_out.ack;

   assign q_out.cmd = mem[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem[wr_ptr_r] <= q_in.cmd;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wr_ptr_r    <= '0;
         rd_ptr_r    <= '0;
         count_r     <= '0;
         q_in.ack    <= 1'b0;
         q_out.req   <= 1'b0;
         out_state_r <= s_out_idle;
      end
      else
      begin
         if (push)
            q_in.ack <= 1'b1;
         else if (!q_in.req)
            q_in.ack <= 1'b0;

         if (push)
            wr_ptr_r <= next_ptr(wr_ptr_r);
         if (pop)
            rd_ptr_r <= next_ptr(rd_ptr_r);
         if (push && !pop)
            count_r <= count_r + 1'b1;
         else if (pop && !push)
            count_r <= count_r - 1'b1;

         case (out_state_r)
            s_out_idle:
               if (count_r != '0)
               begin
                  q_out.req   <= 1'b1;
                  out_state_r <= s_out_req;
               end
            s_out_req:
               if (q_out.ack)
               begin
                  q_out.req   <= 1'b0;
                  out_state_r <= s_out_drain;
               end
            s_out_drain:
               if (!q_out.ack)
                  out_state_r <= s_out_idle;
            default:
               out_state_r <= s_out_idle;
         endcase
      end
   end

endmodule

// File: logic/csr_machine_file.sv
`include "csr_config.svh"

module csr_machine_file
  (input                          clk_i
   , input                        rst_i
   , csr_cmd_if.sink              q_out
   , input                        timer_irq_i
   , input                        software_irq_i
   , input                        external_irq_i
   , output logic                 rsp_req_o
   , input                        rsp_ack_i
   , output logic [`CSR_XLEN-1:0] rsp_data_o
   , output logic                 rsp_trap_o
   , output logic                 rsp_irq_o
   , output logic [3:0]           rsp_cause_o
   , output logic [`CSR_XLEN-1:0] rsp_npc_o
   , output csr_isa_pkg::priv_e   priv_o
   );

   import csr_isa_pkg::*;
   import csr_link_pkg::*;

   localparam int xlen = `CSR_XLEN;
   localparam logic [xlen-1:0] mie_wmask   = xlen'(12'h888);
   localparam logic [xlen-1:0] align_wmask = ~xlen'(3);

   typedef enum logic [1:0] {s_idle, s_respond, s_release, s_ack} state_e;

   state_e          state_r;
   priv_e           priv_r, priv_n;
   mstatus_s        mstatus_r, mstatus_n;
   csr_word_u       wr_word;
   logic [xlen-1:0] mie_r, mie_n;
   logic [xlen-1:0] mtvec_r, mtvec_n;
   logic [xlen-1:0] mscratch_r, mscratch_n;
   logic [xlen-1:0] mepc_r, mepc_n;
   logic [xlen-1:0] mcause_r, mcause_n;
   logic [xlen-1:0] minstret_r, minstret_n;

   csr_cmd_s        cmd;
   logic            start;
   logic [xlen-1:0] mip_w;
   logic [xlen-1:0] irq_act;
   logic [xlen-1:0] src;
   logic [xlen-1:0] old_val;
   logic [xlen-1:0] new_val;
   logic [xlen-1:0] rsp_data_n;
   logic [xlen-1:0] npc_n;
   logic [3:0]      irq_code;
   logic [3:0]      cause_n;
   logic            gie, take_irq, known, writes, read_only, illegal;
   logic            is_csr, is_imm, trap_n, irq_n;

   assign cmd    = q_out.cmd;
   assign start  = (state_r == s_idle) && q_out.req;
   assign priv_o = priv_r;

   // mip mirrors the interrupt lines
   always_comb
   begin
      mip_w     = '0;
      mip_w[3]  = software_irq_i;
      mip_w[7]  = timer_irq_i;
      mip_w[11] = external_irq_i;
   end

   assign irq_act  = mip_w & mie_r;
   assign gie      = (priv_r == e_priv_u) || mstatus_r.mie;
   assign take_irq = gie && (irq_act != '0);

   // External first, then software, then timer
   always_comb
   begin
      if (irq_act[11])
         irq_code = cause_irq_external;
      else if (irq_act[3])
         irq_code = cause_irq_software;
      else
         irq_code = cause_irq_timer;
   end

   assign is_csr    = cmd.op inside {e_csrrw, e_csrrs, e_csrrc, e_csrrwi, e_csrrsi, e_csrrci};
   assign is_imm    = cmd.op inside {e_csrrwi, e_csrrsi, e_csrrci};
   assign src       = is_imm ? xlen'(cmd.data[4:0]) : cmd.data;
   assign writes    = (cmd.op inside {e_csrrw, e_csrrwi}) || (src != '0);
   assign read_only = (cmd.addr[11:10] == 2'b11) || (cmd.addr == e_csr_misa);

   always_comb
   begin
      known = 1'b1;
      case (cmd.addr)
         e_csr_mstatus:  old_val = mstatus_r;
         e_csr_misa:     old_val = xlen'(`CSR_MISA_VALUE);
         e_csr_mie:      old_val = mie_r;
         e_csr_mtvec:    old_val = mtvec_r;
         e_csr_mscratch: old_val = mscratch_r;
         e_csr_mepc:     old_val = mepc_r;
         e_csr_mcause:   old_val = mcause_r;
         e_csr_mip:      old_val = mip_w;
         e_csr_minstret: old_val = minstret_r;
         e_csr_mimpid:   old_val = xlen'(`CSR_MIMPID_VALUE);
         e_csr_mhartid:  old_val = xlen'(`CSR_HART_ID);
         default:
         begin
            known   = 1'b0;
            old_val = '0;
         end
      endcase
   end

   always_comb
   begin
      case (cmd.op)
         e_csrrs, e_csrrsi: new_val = old_val | src;
         e_csrrc, e_csrrci: new_val = old_val & ~src;
         default:           new_val = src;
      endcase
   end

   assign illegal = (cmd.op == e_mret && priv_r == e_priv_u)
                    || (is_csr && (!known || cmd.addr[9:8] > priv_r || (writes && read_only)))
                    || !(is_csr || cmd.op == e_ecall || cmd.op == e_mret);

   always_comb
   begin
      priv_n      = priv_r;
      mstatus_n   = mstatus_r;
      mie_n       = mie_r;
      mtvec_n     = mtvec_r;
      mscratch_n  = mscratch_r;
      mepc_n      = mepc_r;
      mcause_n    = mcause_r;
      minstret_n  = minstret_r;
      wr_word.raw = new_val;
      trap_n      = 1'b0;
      irq_n       = 1'b0;
      cause_n     = '0;
      rsp_data_n  = '0;
      npc_n       = cmd.pc + xlen'(4);

      if (take_irq)
      begin
         trap_n  = 1'b1;
         irq_n   = 1'b1;
         cause_n = irq_code;
      end
      else if (illegal)
      begin
         trap_n  = 1'b1;
         cause_n = cause_illegal_instr;
      end
      else if (cmd.op == e_ecall)
      begin
         trap_n  = 1'b1;
         cause_n = (priv_r == e_priv_u) ? cause_ecall_u : cause_ecall_m;
      end
      else if (cmd.op == e_mret)
      begin
         priv_n         = priv_e'(mstatus_r.mpp);
         mstatus_n.mie  = mstatus_r.mpie;
         mstatus_n.mpie = 1'b1;
         mstatus_n.mpp  = e_priv_u;
         npc_n          = mepc_r;
      end
      else
      begin
         rsp_data_n = old_val;
         minstret_n = minstret_r + 1'b1;
         if (writes)
         begin
            case (cmd.addr)
               e_csr_mstatus:
               begin
                  mstatus_n      = '0;
                  mstatus_n.mie  = wr_word.mstatus.mie;
                  mstatus_n.mpie = wr_word.mstatus.mpie;
                  mstatus_n.mpp  = (wr_word.mstatus.mpp == e_priv_m) ? e_priv_m : e_priv_u;
               end
               e_csr_mie:      mie_n      = wr_word.raw & mie_wmask;
               e_csr_mtvec:    mtvec_n    = wr_word.raw & align_wmask;
               e_csr_mscratch: mscratch_n = wr_word.raw;
               e_csr_mepc:     mepc_n     = wr_word.raw & align_wmask;
               e_csr_mcause:   mcause_n   = wr_word.raw;
               // An explicit write wins over the retire increment
               e_csr_minstret: minstret_n = wr_word.raw;
               default:        ;
            endcase
         end
      end

      if (trap_n)
      begin
         mepc_n         = cmd.pc;
         mcause_n       = {irq_n, {(xlen - 5){1'b0}}, cause_n};
         mstatus_n.mpp  = priv_r;
         mstatus_n.mpie = mstatus_r.mie;
         mstatus_n.mie  = 1'b0;
         priv_n         = e_priv_m;
         npc_n          = mtvec_r;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_r    <= s_idle;
         rsp_req_o  <= 1'b0;
         q_out.ack  <= 1'b0;
         priv_r     <= e_priv_m;
         mstatus_r  <= '0;
         mie_r      <= '0;
         mtvec_r    <= '0;
         mscratch_r <= '0;
         mepc_r     <= '0;
         mcause_r   <= '0;
         minstret_r <= '0;
      end
      else
      begin
         case (state_r)
            s_idle:
               if (start)
               begin
                  rsp_req_o <= 1'b1;
                  state_r   <= s_respond;
               end
            s_respond:
               if (rsp_ack_i)
               begin
                  rsp_req_o <= 1'b0;
                  state_r   <= s_release;
               end
            // Queue is acked only after the response handshake has closed
            s_release:
               if (!rsp_ack_i)
               begin
                  q_out.ack <= 1'b1;
                  state_r   <= s_ack;
               end
            s_ack:
               if (!q_out.req)
               begin
                  q_out.ack <= 1'b0;
                  state_r   <= s_idle;
               end
            default:
               state_r <= s_idle;
         endcase

         if (start)
         begin
            priv_r     <= priv_n;
            mstatus_r  <= mstatus_n;
            mie_r      <= mie_n;
            mtvec_r    <= mtvec_n;
            mscratch_r <= mscratch_n;
            mepc_r     <= mepc_n;
            mcause_r   <= mcause_n;
            minstret_r <= minstret_n;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (start)
      begin
         rsp_data_o  <= rsp_data_n;
         rsp_trap_o  <= trap_n;
         rsp_irq_o   <= irq_n;
         rsp_cause_o <= cause_n;
         rsp_npc_o   <= npc_n;
      end
   end

endmodule

// File: logic/csr_unit.sv
`include "csr_config.svh"

module csr_unit
  (input                          clk_i
   , input                        rst_i
   , input                        cmd_req_i
   , output logic                 cmd_ack_o
   , input csr_isa_pkg::csr_op_e  cmd_op_i
   , input [11:0]                 cmd_addr_i
   , input [`CSR_XLEN-1:0]        cmd_data_i
   , input [`CSR_XLEN-1:0]        cmd_pc_i
   , input                        timer_irq_i
   , input                        software_irq_i
   , input                        external_irq_i
   , output logic                 rsp_req_o
   , input                        rsp_ack_i
   , output logic [`CSR_XLEN-1:0] rsp_data_o
   , output logic                 rsp_trap_o
   , output logic                 rsp_irq_o
   , output logic [3:0]           rsp_cause_o
   , output logic [`CSR_XLEN-1:0] rsp_npc_o
   , output csr_isa_pkg::priv_e   priv_o
   );

   // Intake to queue, queue to CSR file
   csr_cmd_if q_in ();
   csr_cmd_if q_out ();

   csr_cmd_intake intake
     (.clk_i      (clk_i)
      , .rst_i      (rst_i)
      , .cmd_req_i  (cmd_req_i)
      , .cmd_ack_o  (cmd_ack_o)
      , .cmd_op_i   (cmd_op_i)
      , .cmd_addr_i (cmd_addr_i)
      , .cmd_data_i (cmd_data_i)
      , .cmd_pc_i   (cmd_pc_i)
      , .q_in       (q_in.source)
      );

   csr_cmd_queue cmd_queue
     (.clk_i   (clk_i)
      , .rst_i (rst_i)
      , .q_in  (q_in.sink)
      , .q_out (q_out.source)
      );

   csr_machine_file csr_file
     (.clk_i            (clk_i)
      , .rst_i          (rst_i)
      , .q_out          (q_out.sink)
      , .timer_irq_i    (timer_irq_i)
      , .software_irq_i (software_irq_i)
      , .external_irq_i (external_irq_i)
      , .rsp_req_o      (rsp_req_o)
      , .rsp_ack_i      (rsp_ack_i)
      , .rsp_data_o     (rsp_data_o)
      , .rsp_trap_o     (rsp_trap_o)
      , .rsp_irq_o      (rsp_irq_o)
      , .rsp_cause_o    (rsp_cause_o)
      , .rsp_npc_o      (rsp_npc_o)
      , .priv_o         (priv_o)
      );

endmodule

// File: verification/csr_unit_properties.sv
`include "csr_config.svh"

module csr_unit_properties
  (input                         clk_i
   , input                       rst_i
   , input                       cmd_req_i
   , input                       cmd_ack_o
   , input                       rsp_req_o
   , input                       rsp_ack_i
   , input [`CSR_XLEN-1:0]       rsp_data_o
   , input                       rsp_trap_o
   , input                       rsp_irq_o
   , input [3:0]                 rsp_cause_o
   , input [`CSR_XLEN-1:0]       rsp_npc_o
   );

   // Count of failed assertions, watched by the testbench
   int assert_failures = 0;

   // Response request is held until the outside acks
   rsp_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_req_o && !rsp_ack_i |=> rsp_req_o)
      else
      begin
         $error("rsp_req_o dropped before rsp_ack_i");
         assert_failures++;
      end

   cmd_ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(cmd_ack_o) |-> $past(cmd_req_i))
      else
      begin
         $error("cmd_ack_o rose without cmd_req_i");
         assert_failures++;
      end

   rsp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_req_o && !$rose(rsp_req_o) |-> $stable(rsp_data_o) && $stable(rsp_trap_o)
         && $stable(rsp_irq_o) && $stable(rsp_cause_o) && $stable(rsp_npc_o))
      else
      begin
         $error("response ports changed while rsp_req_o was high");
         assert_failures++;
      end

endmodule

bind csr_unit csr_unit_properties props
  (.clk_i         (clk_i)
   , .rst_i       (rst_i)
   , .cmd_req_i   (cmd_req_i)
   , .cmd_ack_o   (cmd_ack_o)
   , .rsp_req_o   (rsp_req_o)
   , .rsp_ack_i   (rsp_ack_i)
   , .rsp_data_o  (rsp_data_o)
   , .rsp_trap_o  (rsp_trap_o)
   , .rsp_irq_o   (rsp_irq_o)
   , .rsp_cause_o (rsp_cause_o)
   , .rsp_npc_o   (rsp_npc_o)
   );

// File: verification/csr_unit_tb.sv
`include "csr_config.svh"

module csr_unit_tb;

   import csr_isa_pkg::*;

   localparam int num_cmds       = 300;
   localparam int timeout_cycles = num_cmds * 40;
   localparam int depth          = `CSR_QUEUE_DEPTH;

   typedef struct packed {
      logic [31:0] data;
      logic        trap;
      logic        irq;
      logic [3:0]  cause;
      logic [31:0] npc;
      logic [1:0]  priv;
   } expect_s;

   logic                 clk_i;
   logic                 rst_i;
   logic                 cmd_req_i;
   logic                 cmd_ack_o;
   csr_op_e              cmd_op_i;
   logic [11:0]          cmd_addr_i;
   logic [`CSR_XLEN-1:0] cmd_data_i;
   logic [`CSR_XLEN-1:0] cmd_pc_i;
   logic                 timer_irq_i;
   logic                 software_irq_i;
   logic                 external_irq_i;
   logic                 rsp_req_o;
   logic                 rsp_ack_i;
   logic [`CSR_XLEN-1:0] rsp_data_o;
   logic                 rsp_trap_o;
   logic                 rsp_irq_o;
   logic [3:0]           rsp_cause_o;
   logic [`CSR_XLEN-1:0] rsp_npc_o;
   priv_e                priv_o;

   integer      seed;
   int          sent;
   int          received;
   int          cycle_count;
   expect_s     expected_q [$];

   // Reference model state
   logic [1:0]  m_priv;
   logic        m_st_mie;
   logic        m_mpie;
   logic [1:0]  m_mpp;
   logic [31:0] m_mie;
   logic [31:0] m_mtvec;
   logic [31:0] m_mscratch;
   logic [31:0] m_mepc;
   logic [31:0] m_mcause;
   logic [31:0] m_minstret;

   csr_unit dut
     (.clk_i            (clk_i)
      , .rst_i          (rst_i)
      , .cmd_req_i      (cmd_req_i)
      , .cmd_ack_o      (cmd_ack_o)
      , .cmd_op_i       (cmd_op_i)
      , .cmd_addr_i     (cmd_addr_i)
      , .cmd_data_i     (cmd_data_i)
      , .cmd_pc_i       (cmd_pc_i)
      , .timer_irq_i    (timer_irq_i)
      , .software_irq_i (software_irq_i)
      , .external_irq_i (external_irq_i)
      , .rsp_req_o      (rsp_req_o)
      , .rsp_ack_i      (rsp_ack_i)
      , .rsp_data_o     (rsp_data_o)
      , .rsp_trap_o     (rsp_trap_o)
      , .rsp_irq_o      (rsp_irq_o)
      , .rsp_cause_o    (rsp_cause_o)
      , .rsp_npc_o      (rsp_npc_o)
      , .priv_o         (priv_o)
      );

   always #2 clk_i = ~clk_i;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("** Error at time %0t: %s is %h, expected %h",
                             $time, name, got, exp));
   endtask

   // CSR forms are drawn more often than ecall and mret
   function automatic csr_op_e pick_op(input int unsigned sel);
      case (sel)
         0, 8:    return e_csrrw;
         1, 9:    return e_csrrs;
         2:       return e_csrrc;
         3:       return e_csrrwi;
         4:       return e_csrrsi;
         5:       return e_csrrci;
         6:       return e_ecall;
         default: return e_mret;
      endcase
   endfunction

   function automatic logic [11:0] pick_addr(input int unsigned sel, input logic [11:0] raw);
      case (sel)
         0, 11:   return e_csr_mstatus;
         1:       return e_csr_misa;
         2, 12:   return e_csr_mie;
         3:       return e_csr_mtvec;
         4:       return e_csr_mscratch;
         5:       return e_csr_mepc;
         6:       return e_csr_mcause;
         7:       return e_csr_mip;
         8:       return e_csr_minstret;
         9:       return e_csr_mimpid;
         10:      return e_csr_mhartid;
         default: return raw;
      endcase
   endfunction

   task automatic predict(input csr_op_e op, input logic [11:0] addr, input logic [31:0] data,
                          input logic [31:0] pc, output expect_s e);
      logic [31:0] mip;
      logic [31:0] pending;
      logic [31:0] src;
      logic [31:0] old;
      logic [31:0] wr;
      logic        is_imm;
      logic        is_csr;
      logic        known;
      logic        writing;
      logic        illegal;
      logic        trap;
      logic        irq;
      logic [3:0]  cause;

      mip      = '0;
      mip[3]   = software_irq_i;
      mip[7]   = timer_irq_i;
      mip[11]  = external_irq_i;
      pending  = mip & m_mie;
      is_imm   = (op == e_csrrwi) || (op == e_csrrsi) || (op == e_csrrci);
      is_csr   = is_imm || (op == e_csrrw) || (op == e_csrrs) || (op == e_csrrc);
      src      = is_imm ? {27'b0, data[4:0]} : data;
      writing  = (op == e_csrrw) || (op == e_csrrwi) || (src != 0);
      known    = 1'b1;
      case (addr)
         e_csr_mstatus:  old = {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_st_mie, 3'b0};
         e_csr_misa:     old = `CSR_MISA_VALUE;
         e_csr_mie:      old = m_mie;
         e_csr_mtvec:    old = m_mtvec;
         e_csr_mscratch: old = m_mscratch;
         e_csr_mepc:     old = m_mepc;
         e_csr_mcause:   old = m_mcause;
         e_csr_mip:      old = mip;
         e_csr_minstret: old = m_minstret;
         e_csr_mimpid:   old = `CSR_MIMPID_VALUE;
         e_csr_mhartid:  old = `CSR_HART_ID;
         default:
         begin
            known = 1'b0;
            old   = '0;
         end
      endcase
      if (op == e_csrrs || op == e_csrrsi)
         wr = old | src;
      else if (op == e_csrrc || op == e_csrrci)
         wr = old & ~src;
      else
         wr = src;
      illegal = (op == e_mret && m_priv == 2'd0)
                || (is_csr && (!known || addr[9:8] > m_priv
                    || (writing && (addr[11:10] == 2'b11 || addr == e_csr_misa))));
      e     = '0;
      e.npc = pc + 32'd4;
      trap  = 1'b0;
      irq   = 1'b0;
      cause = 4'd0;

      if (pending != 0 && (m_priv == 2'd0 || m_st_mie))
      begin
         trap  = 1'b1;
         irq   = 1'b1;
         cause = pending[11] ? 4'd11 : (pending[3] ? 4'd3 : 4'd7);
      end
      else if (illegal)
      begin
         trap  = 1'b1;
         cause = 4'd2;
      end
      else if (op == e_ecall)
      begin
         trap  = 1'b1;
         cause = (m_priv == 2'd0) ? 4'd8 : 4'd11;
      end
      else if (op == e_mret)
      begin
         m_priv   = m_mpp;
         m_st_mie = m_mpie;
         m_mpie   = 1'b1;
         m_mpp    = 2'd0;
         e.npc    = m_mepc;
      end
      else
      begin
         e.data     = old;
         m_minstret = m_minstret + 1;
         if (writing)
         begin
            case (addr)
               e_csr_mstatus:
               begin
                  m_st_mie = wr[3];
                  m_mpie   = wr[7];
                  m_mpp    = (wr[12:11] == 2'd3) ? 2'd3 : 2'd0;
               end
               e_csr_mie:      m_mie      = wr & 32'h888;
               e_csr_mtvec:    m_mtvec    = wr & ~32'h3;
               e_csr_mscratch: m_mscratch = wr;
               e_csr_mepc:     m_mepc     = wr & ~32'h3;
               e_csr_mcause:   m_mcause   = wr;
               e_csr_minstret: m_minstret = wr;
               default:        ;
            endcase
         end
      end

      if (trap)
      begin
         m_mepc   = pc;
         m_mcause = {irq, 27'b0, cause};
         m_mpp    = m_priv;
         m_mpie   = m_st_mie;
         m_st_mie = 1'b0;
         m_priv   = 2'd3;
         e.npc    = m_mtvec;
      end
      e.trap  = trap;
      e.irq   = irq;
      e.cause = cause;
      e.priv  = m_priv;
   endtask

   initial
   begin : drive
      expect_s     e;
      csr_op_e     op;
      logic [11:0] addr;
      logic [31:0] data;
      logic [31:0] pc;

      seed           = 32'hf4836b14;
      clk_i          = 1'b0;
      rst_i          = 1'b1;
      cmd_req_i      = 1'b0;
      cmd_op_i       = e_csrrw;
      cmd_addr_i     = '0;
      cmd_data_i     = '0;
      cmd_pc_i       = '0;
      timer_irq_i    = 1'b0;
      software_irq_i = 1'b0;
      external_irq_i = 1'b0;
      rsp_ack_i      = 1'b0;
      sent           = 0;
      received       = 0;
      m_priv         = 2'd3;
      m_st_mie       = 1'b0;
      m_mpie         = 1'b0;
      m_mpp          = 2'd0;
      m_mie          = '0;
      m_mtvec        = '0;
      m_mscratch     = '0;
      m_mepc         = '0;
      m_mcause       = '0;
      m_minstret     = '0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      for (int i = 0; i < num_cmds; i++)
      begin
         // Interrupt lines move only with nothing in flight
         if (i % 16 == 0)
         begin
            while (received != sent)
               @(negedge clk_i);
            software_irq_i = ($unsigned($random(seed)) % 4) == 0;
            timer_irq_i    = ($unsigned($random(seed)) % 4) == 0;
            external_irq_i = ($unsigned($random(seed)) % 4) == 0;
         end
         op   = pick_op($unsigned($random(seed)) % 10);
         addr = pick_addr($unsigned($random(seed)) % 16, $random(seed));
         data = (($unsigned($random(seed)) % 4) == 0) ? 32'd0 : $random(seed);
         if (op == e_csrrwi || op == e_csrrsi || op == e_csrrci)
            data = data & 32'h1f;
         pc = $random(seed) & ~32'h3;
         predict(op, addr, data, pc, e);
         expected_q.push_back(e);

         cmd_op_i   = op;
         cmd_addr_i = addr;
         cmd_data_i = data;
         cmd_pc_i   = pc;
         cmd_req_i  = 1'b1;
         while (!cmd_ack_o)
            @(negedge clk_i);
         sent++;
         if (sent - received > depth + 1)
            abort_run("More commands were accepted than the queue and intake can hold");
         cmd_req_i = 1'b0;
         while (cmd_ack_o)
            @(negedge clk_i);
      end

      while (received != num_cmds)
         @(negedge clk_i);
      repeat (4) @(negedge clk_i);
      if (dut.props.assert_failures != 0)
         abort_run("A handshake assertion on the DUT failed");
      else
      begin
         $display("All checks passed");
         $finish;
      end
   end

   initial
   begin : respond
      expect_s     e;
      int unsigned delay;

      forever
      begin
         @(negedge clk_i);
         if (rsp_req_o === 1'b1)
         begin
            if (expected_q.size() == 0)
               abort_run("A response arrived with no command outstanding");
            e = expected_q.pop_front();
            check_value("rsp_data_o", rsp_data_o, e.data);
            check_value("rsp_trap_o", rsp_trap_o, e.trap);
            check_value("rsp_irq_o", rsp_irq_o, e.irq);
            check_value("rsp_cause_o", rsp_cause_o, e.cause);
            check_value("rsp_npc_o", rsp_npc_o, e.npc);
            check_value("priv_o", priv_o, e.priv);
            received++;
            // A long hold now and then lets the queue fill up
            delay = $unsigned($random(seed)) % 6;
            if (received % 50 == 0)
               delay = 30;
            repeat (delay) @(negedge clk_i);
            rsp_ack_i = 1'b1;
            while (rsp_req_o)
               @(negedge clk_i);
            rsp_ack_i = 1'b0;
         end
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles)
      begin
         @(posedge clk_i);
         cycle_count++;
         if (dut.props.assert_failures != 0)
            abort_run("A handshake assertion on the DUT failed");
      end
      abort_run("Timeout: the run did not finish within the cycle limit");
   end

endmodule

// File: csr_unit.f
+incdir+include
logic/csr_isa_pkg.sv
logic/csr_link_pkg.sv
logic/csr_cmd_if.sv
logic/csr_cmd_intake.sv
logic/csr_cmd_queue.sv
logic/csr_machine_file.sv
logic/csr_unit.sv
verification/csr_unit_properties.sv
verification/csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - logic/csr_isa_pkg.sv
  - logic/csr_link_pkg.sv
  - logic/csr_cmd_if.sv
  - logic/csr_cmd_intake.sv
  - logic/csr_cmd_queue.sv
  - logic/csr_machine_file.sv
  - logic/csr_unit.sv
  - target: test
    files:
      - verification/csr_unit_properties.sv
      - verification/csr_unit_tb.sv
